// File: vlog.f
+incdir+.
agu_pkg.sv
kogge_stone_adder.sv
imm_decoder.sv
address_generator.sv
branch_compare.sv
control_unit.sv
addr_unit_top.sv
tb_addr_unit.sv

// File: tb_addr_model.svh
`ifndef TB_ADDR_MODEL_SVH
`define TB_ADDR_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Register fields are unused by the unit, fixed at x1 and x2
function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                      input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], agu_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], agu_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, agu_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, agu_pkg::OPC_AUIPC};
endfunction

// The six RV32I branch conditions
function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Operands around zero and the signed and unsigned wrap points
function automatic logic [31:0] edge_operand(input logic [2:0] sel);
    case (sel)
        3'd0:    return 32'h0000_0000;
        3'd1:    return 32'h0000_0001;
        3'd2:    return 32'h7fff_ffff;
        3'd3:    return 32'h8000_0000;
        3'd4:    return 32'hffff_ffff;
        3'd5:    return 32'hffff_fffe;
        3'd6:    return 32'h8000_0001;
        default: return 32'h7fff_fffe;
    endcase
endfunction

`endif

// File: tb_addr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_addr_unit;

    localparam int N_MEM      = 200;
    localparam int N_JUMP     = 120;
    localparam int N_BRANCH   = 180;
    // Memory ops may add an idle cycle, each trap case takes under 20 cycles
    localparam int MAX_CYCLES = 23 + 2 * N_MEM + N_JUMP + N_BRANCH + 7 * 20 + 100;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    agu_pkg::word_t     instr;
    agu_pkg::word_t     rs1_data;
    agu_pkg::word_t     rs2_data;
    agu_pkg::word_t     pc;
    agu_pkg::word_t     mem_addr;
    agu_pkg::word_t     store_data;
    logic               load_strobe;
    logic               store_strobe;
    logic               rd_we;
    agu_pkg::reg_addr_t rd_addr;
    agu_pkg::word_t     rd_data;
    logic               trap;

    // Expected outputs after the next rising edge, x while still undefined
    logic [31:0] m_pc, m_mem_addr, m_store_data, m_rd_data, m_rd_addr;
    logic        m_load, m_store, m_we, m_trap;
    logic [31:0] rng_state;
    int          checks, errors, test_checks, test_errors, cycles;

    `include "tb_addr_model.svh"

    addr_unit_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .mem_addr     (mem_addr),
        .store_data   (store_data),
        .load_strobe  (load_strobe),
        .store_strobe (store_strobe),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .trap         (trap)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (!$isunknown(exp)) begin
            checks++;
            assert (got === exp) else begin
                errors++;
                $display("error %s: got %h, expected %h", name, got, exp);
            end
        end
    endtask

    task automatic check_outputs();
        check_value("pc", pc, m_pc);
        check_value("mem_addr", mem_addr, m_mem_addr);
        check_value("store_data", store_data, m_store_data);
        check_value("rd_data", rd_data, m_rd_data);
        check_value("rd_addr", rd_addr, m_rd_addr);
        check_value("load_strobe", load_strobe, m_load);
        check_value("store_strobe", store_strobe, m_store);
        check_value("rd_we", rd_we, m_we);
        check_value("trap", trap, m_trap);
    endtask

    task automatic model_accept(input logic [31:0] ins, input logic [31:0] a,
                                input logic [31:0] b, input logic [31:0] imm);
        logic [6:0]  opc;
        logic [31:0] tgt;
        logic        redirect;
        logic        bad;
        opc      = ins[6:0];
        tgt      = 32'd0;
        redirect = 1'b0;
        bad      = 1'b0;
        case (opc)
            agu_pkg::OPC_LOAD, agu_pkg::OPC_STORE: tgt = a + imm;
            agu_pkg::OPC_JALR: begin
                tgt      = (a + imm) & ~32'd1;
                redirect = 1'b1;
            end
            agu_pkg::OPC_JAL, agu_pkg::OPC_AUIPC: begin
                tgt      = m_pc + imm;
                redirect = (opc == agu_pkg::OPC_JAL);
            end
            agu_pkg::OPC_BRANCH: begin
                tgt      = m_pc + imm;
                bad      = (ins[14:12] == 3'd2) || (ins[14:12] == 3'd3);
                redirect = branch_holds(ins[14:12], a, b);
            end
            default: bad = 1'b1;
        endcase
        if (bad || (redirect && tgt[1])) begin
            m_trap = 1'b1;
        end else begin
            m_load  = (opc == agu_pkg::OPC_LOAD);
            m_store = (opc == agu_pkg::OPC_STORE);
            m_we    = (opc == agu_pkg::OPC_JAL) || (opc == agu_pkg::OPC_JALR) ||
                      (opc == agu_pkg::OPC_AUIPC);
            if (m_load || m_store)
                m_mem_addr = tgt;
            if (m_store)
                m_store_data = b;
            // Link value uses the pc before the jump
            if (m_we)
                m_rd_data = (opc == agu_pkg::OPC_AUIPC) ? tgt : m_pc + 32'd4;
            if (m_we)
                m_rd_addr = {27'd0, ins[11:7]};
            m_pc = redirect ? tgt : m_pc + 32'd4;
        end
    endtask

    // Check the previous cycle's results, then drive the next cycle
    task automatic step(input logic valid, input logic [31:0] ins, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] imm);
        @(posedge clk);
        #2;
        check_outputs();
        instr_valid = valid;
        instr       = ins;
        rs1_data    = a;
        rs2_data    = b;
        m_load      = 1'b0;
        m_store     = 1'b0;
        m_we        = 1'b0;
        if (valid && !m_trap)
            model_accept(ins, a, b, imm);
    endtask

    task automatic idle();
        step(1'b0, rand_word(), rand_word(), rand_word(), 32'd0);
    endtask

    task automatic reset_dut();
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n        = 1'b1;
        m_pc         = agu_pkg::RESET_PC;
        m_mem_addr   = 'x;
        m_store_data = 'x;
        m_rd_data    = 'x;
        m_rd_addr    = 'x;
        m_load       = 1'b0;
        m_store      = 1'b0;
        m_we         = 1'b0;
        m_trap       = 1'b0;
    endtask

    task automatic load_or_store();
        logic [31:0] r;
        logic [31:0] imm;
        r   = rand_word();
        imm = {{20{r[11]}}, r[11:0]};
        if (r[31])
            step(1'b1, enc_s(imm[11:0]), rand_word(), rand_word(), imm);
        else
            step(1'b1, enc_i(agu_pkg::OPC_LOAD, r[16:12], 3'b010, imm[11:0]),
                 rand_word(), rand_word(), imm);
        // An idle gap now and then
        if (r[30:28] == 3'd0)
            idle();
    endtask

    task automatic jump_or_auipc();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        r = rand_word();
        s = rand_word();
        a = rand_word();
        case (s % 3)
            0: begin
                imm = {{11{r[20]}}, r[20:2], 2'b00};
                step(1'b1, enc_j(s[12:8], imm[20:0]), a, r, imm);
            end
            1: begin
                imm = {{20{r[11]}}, r[11:0]};
                // Flipping rs1 bit 1 flips target bit 1, keeps it word aligned
                b = a + imm;
                if (b[1])
                    a = a ^ 32'd2;
                step(1'b1, enc_i(agu_pkg::OPC_JALR, s[12:8], 3'b000, imm[11:0]), a, b, imm);
            end
            default: begin
                imm = {r[31:12], 12'd0};
                step(1'b1, enc_u(s[12:8], imm[31:12]), a, s, imm);
            end
        endcase
    endtask

    task automatic branch_op();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [2:0]  f3;
        r  = rand_word();
        s  = rand_word();
        a  = rand_word();
        b  = rand_word();
        f3 = s % 6;
        if (f3 >= 3'd2)
            f3 = f3 + 3'd2;
        imm = {{19{r[12]}}, r[12:2], 2'b00};
        // Bias toward equal operands and the sign boundaries
        if (s[4:3] == 2'd0) begin
            b = a;
        end else if (s[4:3] == 2'd1) begin
            a = edge_operand(r[15:13]);
            b = edge_operand(r[18:16]);
        end
        step(1'b1, enc_b(f3, imm[12:0]), a, b, imm);
    endtask

    task automatic trap_case(input logic [31:0] ins, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] imm);
        load_or_store();
        jump_or_auipc();
        step(1'b1, ins, a, b, imm);
        repeat (4) load_or_store();
        idle();
        reset_dut();
        idle();
    endtask

    task automatic end_test(input int num, input string name);
        idle();
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        rng_state   = 32'he4af;
        reset_dut();

        repeat (4) idle();
        load_or_store();
        load_or_store();
        jump_or_auipc();
        repeat (6) idle();
        end_test(1, "reset and idle");

        repeat (N_MEM) load_or_store();
        end_test(2, "load and store");

        repeat (N_JUMP) jump_or_auipc();
        end_test(3, "jal, jalr and auipc");

        repeat (N_BRANCH) branch_op();
        end_test(4, "branches");

        // Misaligned target on a branch that is not taken
        step(1'b1, enc_b(3'b001, 13'h6), 32'd5, 32'd5, 32'd6);
        trap_case(enc_i(7'b0110011, 5'd3, 3'b000, 12'h0), rand_word(), rand_word(), 32'd0);
        trap_case(enc_b(3'b010, 13'h8), rand_word(), rand_word(), 32'd8);
        trap_case(enc_b(3'b011, 13'h8), rand_word(), rand_word(), 32'd8);
        trap_case(enc_j(5'd1, 21'h6), 32'd0, 32'd0, 32'd6);
        trap_case(enc_i(agu_pkg::OPC_JALR, 5'd1, 3'b000, 12'h0), 32'h0000_2002, 32'd0, 32'd0);
        trap_case(enc_b(3'b000, 13'h6), 32'd7, 32'd7, 32'd6);
        end_test(5, "traps");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: addr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module addr_unit_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  agu_pkg::word_t      instr,
    input  agu_pkg::word_t      rs1_data,
    input  agu_pkg::word_t      rs2_data,
    output agu_pkg::word_t      pc,
    output agu_pkg::word_t      mem_addr,
    output agu_pkg::word_t      store_data,
    output logic                load_strobe,
    output logic                store_strobe,
    output logic                rd_we,
    output agu_pkg::reg_addr_t  rd_addr,
    output agu_pkg::word_t      rd_data,
    output logic                trap
);

    agu_pkg::opcode_t   opcode;
    agu_pkg::funct3_t   funct3;
    agu_pkg::reg_addr_t rd;
    agu_pkg::word_t     imm;
    agu_pkg::word_t     target;
    agu_pkg::word_t     pc_plus_4;
    logic               taken;
    logic               cond_valid;

    // Fixed RV32I field positions
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    imm_decoder u_imm_decoder (
        .instr (instr),
        .imm   (imm)
    );

    address_generator u_address_generator (
        .opcode    (opcode),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .imm       (imm),
        .target    (target),
        .pc_plus_4 (pc_plus_4)
    );

    branch_compare u_branch_compare (
        .funct3     (funct3),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .taken      (taken),
        .cond_valid (cond_valid)
    );

    control_unit u_control_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .opcode       (opcode),
        .rd           (rd),
        .rs2_data     (rs2_data),
        .target       (target),
        .pc_plus_4    (pc_plus_4),
        .taken        (taken),
        .cond_valid   (cond_valid),
        .pc           (pc),
        .mem_addr     (mem_addr),
        .store_data   (store_data),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .load_strobe  (load_strobe),
        .store_strobe (store_strobe),
        .rd_we        (rd_we),
        .trap         (trap)
    );

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  agu_pkg::opcode_t    opcode,
    input  agu_pkg::reg_addr_t  rd,
    input  agu_pkg::word_t      rs2_data,
    input  agu_pkg::word_t      target,
    input  agu_pkg::word_t      pc_plus_4,
    input  logic                taken,
    input  logic                cond_valid,
    output agu_pkg::word_t      pc,
    output agu_pkg::word_t      mem_addr,
    output agu_pkg::word_t      store_data,
    output agu_pkg::word_t      rd_data,
    output agu_pkg::reg_addr_t  rd_addr,
    output logic                load_strobe,
    output logic                store_strobe,
    output logic                rd_we,
    output logic                trap
);

    agu_pkg::ctrl_state_t state;

    logic is_load, is_store, is_branch, is_jal, is_jalr, is_auipc;
    logic known_op;
    logic redirect;
    logic trap_hit;
    logic accept;

    assign is_load   = (opcode == agu_pkg::OPC_LOAD);
    assign is_store  = (opcode == agu_pkg::OPC_STORE);
    assign is_branch = (opcode == agu_pkg::OPC_BRANCH);
    assign is_jal    = (opcode == agu_pkg::OPC_JAL);
    assign is_jalr   = (opcode == agu_pkg::OPC_JALR);
    assign is_auipc  = (opcode == agu_pkg::OPC_AUIPC);

    assign known_op = is_load | is_store | is_branch | is_jal | is_jalr | is_auipc;
    assign redirect = is_jal | is_jalr | (is_branch & taken);

    // Misaligned redirect, reserved branch condition or unknown opcode
    assign trap_hit = !known_op || (is_branch && !cond_valid) || (redirect && target[1]);
    assign accept   = instr_valid && (state == agu_pkg::CTRL_RUN);
    assign trap     = (state == agu_pkg::CTRL_TRAP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= agu_pkg::CTRL_RUN;
            pc           <= agu_pkg::RESET_PC;
            load_strobe  <= 1'b0;
            store_strobe <= 1'b0;
            rd_we        <= 1'b0;
        end else begin
            load_strobe  <= 1'b0;
            store_strobe <= 1'b0;
            rd_we        <= 1'b0;
            if (accept) begin
                if (trap_hit) begin
                    state <= agu_pkg::CTRL_TRAP;
                end else begin
                    pc           <= redirect ? target : pc_plus_4;
                    load_strobe  <= is_load;
                    store_strobe <= is_store;
                    rd_we        <= is_jal | is_jalr | is_auipc;
                end
            end
        end
    end

    // Result registers, cleared so idle outputs start known
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_addr   <= '0;
            store_data <= '0;
            rd_data    <= '0;
            rd_addr    <= '0;
        end else if (accept && !trap_hit) begin
            if (is_load || is_store) begin
                mem_addr <= target;
            end
            if (is_store) begin
                store_data <= rs2_data;
            end
            if (is_jal || is_jalr) begin
                rd_data <= pc_plus_4;
                rd_addr <= rd;
            end else if (is_auipc) begin
                rd_data <= target;
                rd_addr <= rd;
            end
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_strobe && store_strobe))
        else $error("load and store strobes high together");

    a_quiet_in_trap: assert property (@(posedge clk) disable iff (!rst_n)
        trap |-> !(load_strobe || store_strobe || rd_we))
        else $error("strobe active in trap state");

    // Depends on the adder and the trap check together
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

`default_nettype wire

// File: branch_compare.sv
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
    input  agu_pkg::funct3_t funct3,
    input  agu_pkg::word_t   rs1_data,
    input  agu_pkg::word_t   rs2_data,
    output logic             taken,
    output logic             cond_valid
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_data == rs2_data);
    assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
    assign lt_u = (rs1_data < rs2_data);

    always_comb begin
        cond_valid = 1'b1;
        case (funct3)
            3'b000:  taken = eq;
            3'b001:  taken = !eq;
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;
            // Encodings 2 and 3 are reserved
            default: begin
                taken      = 1'b0;
                cond_valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: address_generator.sv
`timescale 1ns/1ps
`default_nettype none

module address_generator (
    input  agu_pkg::opcode_t opcode,
    input  agu_pkg::word_t   pc,
    input  agu_pkg::word_t   rs1_data,
    input  agu_pkg::word_t   imm,
    output agu_pkg::word_t   target,
    output agu_pkg::word_t   pc_plus_4
);

    agu_pkg::word_t base;
    agu_pkg::word_t sum;

    // Register relative for memory ops and JALR, pc relative otherwise
    always_comb begin
        case (opcode)
            agu_pkg::OPC_LOAD,
            agu_pkg::OPC_STORE,
            agu_pkg::OPC_JALR: base = rs1_data;
            default:           base = pc;
        endcase
    end

    kogge_stone_adder #(
        .WIDTH     (agu_pkg::XLEN)
    ) u_target_adder (
        .carry_in  (1'b0),
        .a         (base),
        .b         (imm),
        .sum       (sum),
        .carry_out ()
    );

    kogge_stone_adder #(
        .WIDTH     (agu_pkg::XLEN)
    ) u_seq_adder (
        .carry_in  (1'b0),
        .a         (pc),
        .b         (32'd4),
        .sum       (pc_plus_4),
        .carry_out ()
    );

    // JALR clears the lowest target bit
    always_comb begin
        target = sum;
        if (opcode == agu_pkg::OPC_JALR) begin
            target[0] = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: imm_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module imm_decoder (
    input  agu_pkg::word_t instr,
    output agu_pkg::word_t imm
);

    agu_pkg::opcode_t opcode;
    agu_pkg::word_t   imm_i;
    agu_pkg::word_t   imm_s;
    agu_pkg::word_t   imm_b;
    agu_pkg::word_t   imm_u;
    agu_pkg::word_t   imm_j;

    assign opcode = instr[6:0];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // Branch and jump offsets are in halfwords, bit 0 is implied
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            agu_pkg::OPC_LOAD,
            agu_pkg::OPC_JALR:   imm = imm_i;
            agu_pkg::OPC_STORE:  imm = imm_s;
            agu_pkg::OPC_BRANCH: imm = imm_b;
            agu_pkg::OPC_AUIPC:  imm = imm_u;
            agu_pkg::OPC_JAL:    imm = imm_j;
            default:             imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: kogge_stone_adder.sv
`timescale 1ns/1ps
`default_nettype none

module kogge_stone_adder #(
    parameter int WIDTH = 32
) (
    input  logic             carry_in,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum,
    output logic             carry_out
);

    localparam int STAGES = $clog2(WIDTH);

    wire [WIDTH-1:0] p_bit;
    wire [WIDTH-1:0] g_st [STAGES+1];
    wire [WIDTH-1:0] p_st [STAGES+1];

    // Bit generate and propagate, carry in folded into bit 0
    assign p_bit    = a ^ b;
    assign p_st[0]  = p_bit;
    assign g_st[0]  = {a[WIDTH-1:1] & b[WIDTH-1:1],
                       (a[0] & b[0]) | (p_bit[0] & carry_in)};

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        localparam int D = 1 << s;

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i < D) begin : g_pass
                assign g_st[s+1][i] = g_st[s][i];
                assign p_st[s+1][i] = p_st[s][i];
            end else if (i < 2 * D) begin : g_grey
                // Group reaches bit 0, only generate matters from here
                assign g_st[s+1][i] = g_st[s][i] | (p_st[s][i] & g_st[s][i-D]);
                assign p_st[s+1][i] = p_st[s][i];
            end else begin : g_black
                assign g_st[s+1][i] = g_st[s][i] | (p_st[s][i] & g_st[s][i-D]);
                assign p_st[s+1][i] = p_st[s][i] & p_st[s][i-D];
            end
        end
    end

    // Carry into bit i is the group generate of bits i-1 down to 0
    assign sum       = p_bit ^ {g_st[STAGES][WIDTH-2:0], carry_in};
    assign carry_out = g_st[STAGES][WIDTH-1];

endmodule

`default_nettype wire

// File: agu_pkg.sv
`default_nettype none

package agu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [4:0]      reg_addr_t;

    // RV32I major opcodes handled by the unit
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    localparam word_t RESET_PC = 32'h0000_1000;

    typedef enum logic {
        CTRL_RUN,
        CTRL_TRAP
    } ctrl_state_t;

endpackage

`default_nettype wire
